// ==== obj_line_builder.f ====
src/obj_cfg_pkg.sv
src/obj_types_pkg.sv
src/obj_frame_fetch.sv
src/obj_vmatch.sv
src/obj_line_table.sv
src/obj_line_builder.sv
verification/obj_line_builder_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module obj_line_builder_tb \
    -f obj_line_builder.f \
    -o obj_line_builder_sim

sim_out=$(./obj_dir/obj_line_builder_sim)
echo "$sim_out"

if grep -q "Regression passed" <<< "$sim_out"; then
    exit 0
fi
exit 1

// ==== src/obj_cfg_pkg.sv ====
// object engine configuration
// sizes of the frame table, the line table and the tile geometry

package obj_cfg_pkg;

    // frame table
    localparam int frame_aw   = 10;    // word address width
    localparam int entry_cnt  = 256;   // sprite entries per frame
    localparam int word_w     = 16;

    // line table
    localparam int line_slots = 128;   // slots per bank
    localparam int slot_words = 4;
    localparam int slot_aw    = $clog2(line_slots);

    // geometry
    localparam int tile_px    = 16;    // tile width and height
    localparam int vpos_w     = 9;
    localparam int nib_w      = 4;

    localparam logic [word_w-1:0] fill_word = '1; // marks an unused slot

endpackage

// ==== src/obj_frame_fetch.sv ====
// frame table fetch unit
// reads each sprite entry from the top of the table down and flags repeats

`timescale 1ns/10ps

module obj_frame_fetch
    import obj_cfg_pkg::*, obj_types_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        scan_start,
    input  logic        next_entry,
    output frame_addr_t frame_addr,
    input  word_t       frame_data,
    output obj_entry_t  entry,
    output logic        entry_valid,
    output logic        repeated,
    output logic        last
);

    fetch_st_e  st;
    logic [2:0] step;      // read pipeline position
    obj_entry_t prev;
    logic       prev_ok;   // prev holds an entry of this scan
    logic       fetched;   // at least one entry assembled this scan

    assign entry_valid = (st == fetch_hold);
    assign repeated    = prev_ok && (entry == prev);
    assign last        = (st == fetch_hold) && (frame_addr[frame_aw-1:2] == '0);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            st         <= fetch_idle;
            frame_addr <= '1;
            step       <= '0;
            prev_ok    <= 1'b0;
            fetched    <= 1'b0;
        end else begin
            if (scan_start) begin
                st         <= fetch_read;
                frame_addr <= frame_addr_t'(entry_cnt * slot_words - 1); // attr of entry 255
                step       <= '0;
                prev_ok    <= 1'b0;
                fetched    <= 1'b0;
            end else begin
                case (st)
                    fetch_read: begin
                        step <= step + 3'd1;
                        if (step < 3'd3)
                            frame_addr <= frame_addr - frame_addr_t'(1);
                        if (step == 3'd1)
                            prev_ok <= fetched;
                        if (step == 3'd4) begin
                            fetched <= 1'b1;
                            st      <= fetch_hold;
                        end
                    end
                    fetch_hold: begin
                        if (next_entry) begin
                            // 4k - 1 is the attr word of entry k - 1
                            frame_addr <= frame_addr - frame_addr_t'(1);
                            step       <= '0;
                            st         <= fetch_read;
                        end
                    end
                    default: ; // idle until the next scan
                endcase
            end
        end
    end

    // entry words arrive one clock after their address
    always_ff @(posedge clk) begin
        if (st == fetch_read) begin
            case (step)
                3'd1: begin
                    prev       <= entry;
                    entry.attr <= frame_data;
                end
                3'd2: entry.code <= frame_data;
                3'd3: entry.y    <= frame_data;
                3'd4: entry.x    <= frame_data;
                default: ;
            endcase
        end
    end

endmodule

// ==== src/obj_line_builder.sv ====
// per-scanline sprite table builder
// fetch unit, vertical match and line table

`timescale 1ns/10ps

module obj_line_builder
    import obj_types_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  vpos_t       vrender,
    input  logic        start,
    output frame_addr_t frame_addr,
    input  word_t       frame_data,
    input  line_addr_t  line_addr,
    output word_t       line_data,
    output logic        done
);

    obj_entry_t entry;
    vmatch_t    vm;
    logic       entry_valid;
    logic       repeated;
    logic       last;
    logic       scan_start;
    logic       next_entry;

    obj_frame_fetch obj_frame_fetch_i (
        .clk         (clk),
        .rst         (rst),
        .scan_start  (scan_start),
        .next_entry  (next_entry),
        .frame_addr  (frame_addr),
        .frame_data  (frame_data),
        .entry       (entry),
        .entry_valid (entry_valid),
        .repeated    (repeated),
        .last        (last)
    );

    obj_vmatch obj_vmatch_i (
        .entry   (entry),
        .vrender (vrender),
        .result  (vm)
    );

    obj_line_table obj_line_table_i (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .vrender     (vrender),
        .entry       (entry),
        .entry_valid (entry_valid),
        .repeated    (repeated),
        .last        (last),
        .vm          (vm),
        .scan_start  (scan_start),
        .next_entry  (next_entry),
        .done        (done),
        .line_addr   (line_addr),
        .line_data   (line_data)
    );

endmodule

// ==== src/obj_line_table.sv ====
// line table builder
// keeps covering sprites, expands their tiles into slots and fills the rest
// two line banks, the renderer reads the one not being written

`timescale 1ns/10ps

module obj_line_table
    import obj_cfg_pkg::*, obj_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  vpos_t      vrender,
    input  obj_entry_t entry,
    input  logic       entry_valid,
    input  logic       repeated,
    input  logic       last,
    input  vmatch_t    vm,
    output logic       scan_start,
    output logic       next_entry,
    output logic       done,
    input  line_addr_t line_addr,
    output word_t      line_data
);

    word_t mem [2*line_slots*slot_words];

    line_st_e           st;
    logic [slot_aw-1:0] slot;
    logic [1:0]         wsel;   // word within the slot
    nib_t               n;      // horizontal tile index

    logic  kept;
    logic  tile_last;
    logic  word_end;
    logic  line_full;
    logic  we;
    word_t code_mn;
    word_t wdata;

    assign kept      = vm.inzone && !repeated;
    assign tile_last = (n == entry.attr[11:8]);
    assign word_end  = (wsel == 2'd2);  // word 3 never written
    assign line_full = &slot;           // slot 127

    always_comb begin
        code_mn = {entry.code[15:8], entry.code[7:4] + vm.m, entry.code[3:0] + n};

        scan_start = (st == line_idle) && start;
        next_entry = 1'b0;
        case (st)
            line_wait: next_entry = entry_valid && !kept && !last;
            line_tile: next_entry = word_end && !line_full && tile_last && !last;
            default:   next_entry = 1'b0;
        endcase

        we = (st == line_tile) || (st == line_fill);
        if (st == line_fill) begin
            wdata = fill_word;
        end else begin
            case (wsel)
                2'd0:    wdata = {4'd0, vm.vsub, entry.attr[7:0]};
                2'd1:    wdata = code_mn;
                default: wdata = entry.x + word_t'(n) * word_t'(tile_px);
            endcase
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            st   <= line_idle;
            slot <= '0;
            wsel <= '0;
            n    <= '0;
            done <= 1'b0;
        end else begin
            case (st)
                line_idle: begin
                    if (start) begin
                        done <= 1'b0;
                        slot <= '0;
                        wsel <= '0;
                        st   <= line_wait;
                    end
                end
                line_wait: begin
                    if (entry_valid) begin
                        wsel <= '0;
                        n    <= '0;
                        if (kept)
                            st <= line_tile;
                        else if (last)
                            st <= line_fill;
                    end
                end
                line_tile: begin
                    wsel <= wsel + 2'd1;
                    if (word_end) begin
                        wsel <= '0;
                        if (line_full) begin
                            // table full, drop whatever is left
                            done <= 1'b1;
                            st   <= line_idle;
                        end else begin
                            slot <= slot + 1'b1;
                            if (!tile_last)
                                n <= n + 4'd1;
                            else if (last)
                                st <= line_fill;
                            else
                                st <= line_wait;
                        end
                    end
                end
                line_fill: begin
                    wsel <= wsel + 2'd1;
                    if (word_end) begin
                        wsel <= '0;
                        slot <= slot + 1'b1;
                        if (line_full) begin
                            done <= 1'b1;
                            st   <= line_idle;
                        end
                    end
                end
                default: st <= line_idle;
            endcase
        end
    end

    // write bank follows vrender, the renderer sees the other one
    always_ff @(posedge clk) begin
        if (we)
            mem[{vrender[0], slot, wsel}] <= wdata;
        line_data <= mem[{~vrender[0], line_addr}];
    end

endmodule

// ==== src/obj_types_pkg.sv ====
// object engine types
// table words, addresses, sprite entries and state encodings

package obj_types_pkg;
    import obj_cfg_pkg::*;

    typedef logic [word_w-1:0]       word_t;
    typedef logic [frame_aw-1:0]     frame_addr_t;
    typedef logic [vpos_w-1:0]       vpos_t;
    typedef logic [slot_aw+1:0]      line_addr_t;  // {slot, word}
    typedef logic [nib_w-1:0]        nib_t;

    // attr: tile_m 15:12, tile_n 11:8, vflip 6, hflip 5, palette 4:0
    typedef struct packed {
        word_t x;
        word_t y;
        word_t code;
        word_t attr;
    } obj_entry_t;

    typedef struct packed {
        logic inzone;
        nib_t m;     // tile row
        nib_t vsub;  // row within the tile, flip applied
    } vmatch_t;

    typedef enum logic [1:0] {
        fetch_idle,
        fetch_read,
        fetch_hold
    } fetch_st_e;

    typedef enum logic [1:0] {
        line_idle,
        line_wait,
        line_tile,
        line_fill
    } line_st_e;

endpackage

// ==== src/obj_vmatch.sv ====
// vertical coverage test
// finds whether the sprite covers the scanline, and which tile row and sub-row

`timescale 1ns/10ps

module obj_vmatch
    import obj_cfg_pkg::*, obj_types_pkg::*;
(
    input  obj_entry_t entry,
    input  vpos_t      vrender,
    output vmatch_t    result
);

    vpos_t      row;    // line offset from the sprite top
    nib_t       tile_m;
    logic       vflip;
    logic [9:0] span;   // sprite height in lines

    assign tile_m = entry.attr[15:12];
    assign vflip  = entry.attr[6];

    always_comb begin
        row  = vrender - entry.y[vpos_w-1:0];  // wraps mod 512
        span = (10'(tile_m) + 10'd1) * 10'(tile_px);

        result.inzone = (10'(row) < span);
        result.m      = nib_t'(row >> 4);
        result.vsub   = row[3:0] ^ {nib_w{vflip}};
    end

endmodule

// ==== verification/obj_line_builder_tb.sv ====
// testbench for the per-scanline sprite table builder
// models the frame table, builds the expected line and reads back the finished bank

`timescale 1ns/10ps

module obj_line_builder_tb
    import obj_cfg_pkg::*, obj_types_pkg::*;
();

    localparam int test_cnt    = 8;
    localparam int cycle_limit = test_cnt * 6000;
    localparam int exp_words   = line_slots * 3;   // words 0..2 of every slot

    logic        clk;
    logic        rst;
    vpos_t       vrender;
    logic        start;
    frame_addr_t frame_addr;
    word_t       frame_data = '0;
    line_addr_t  line_addr;
    word_t       line_data;
    logic        done;

    word_t  ftab [entry_cnt*slot_words];  // frame table model
    word_t  exp_tab [exp_words];
    integer seed;
    int     err_cnt;
    int     pass_cnt;
    int     fail_cnt;
    int     cycles;
    string  cur_test;

    always #20 clk = ~clk;

    always @(posedge clk) frame_data <= ftab[frame_addr];  // one clock read latency

    obj_line_builder obj_line_builder_i (
        .clk        (clk),
        .rst        (rst),
        .vrender    (vrender),
        .start      (start),
        .frame_addr (frame_addr),
        .frame_data (frame_data),
        .line_addr  (line_addr),
        .line_data  (line_data),
        .done       (done)
    );

    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: no result after %0d clock cycles", cycle_limit);
        $display("Regression failed");
        $finish;
    end

    task automatic check_value(input string what, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            err_cnt++;
            $display("CHECK FAILED %s %s: expected %h, actual %h",
                     cur_test, what, expected, actual);
        end
    endtask

    // outputs while reset is held
    task automatic check_reset();
        int errs_before;
        errs_before = err_cnt;
        cur_test    = "reset";
        check_value("frame_addr", 16'h03ff, word_t'(frame_addr));  // all ones
        check_value("done", 16'd0, word_t'(done));
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("test reset: ok");
        end else begin
            fail_cnt++;
            $display("test reset: %0d mismatches", err_cnt - errs_before);
        end
    endtask

    // y puts every entry 256 lines away and out of reach of any sprite height
    task automatic clear_table(input vpos_t vline);
        vpos_t far_y;
        far_y = vline + vpos_t'(256);
        for (int k = 0; k < entry_cnt; k++) begin
            ftab[4*k]   = {6'h2a, 10'(4*k)};
            ftab[4*k+1] = {7'(k), far_y};
            ftab[4*k+2] = {6'h15, 10'(4*k+2)};
            ftab[4*k+3] = {8'(k), 8'(k) ^ 8'h9c};
        end
    endtask

    task automatic put_entry(input int k, input word_t x, input word_t y,
                             input word_t code, input word_t attr);
        ftab[4*k]   = x;
        ftab[4*k+1] = y;
        ftab[4*k+2] = code;
        ftab[4*k+3] = attr;
    endtask

    task automatic random_table(input vpos_t vline);
        int    r;
        word_t attr;
        word_t y;
        for (int k = entry_cnt - 1; k >= 0; k--) begin
            r = $random(seed);
            if (k < entry_cnt - 1 && r[4:2] == 3'd0) begin
                for (int w = 0; w < slot_words; w++)
                    ftab[4*k+w] = ftab[4*(k+1)+w];  // same as the entry scanned before
            end else begin
                attr        = word_t'($random(seed));
                attr[15:12] = {2'b00, attr[13:12]};  // up to 4 rows
                attr[11:8]  = {2'b00, attr[9:8]};    // up to 4 tiles
                if (r[1:0] == 2'd0)
                    y = word_t'(vline - vpos_t'(r[13:8]));
                else
                    y = word_t'($random(seed));
                put_entry(k, word_t'($random(seed)), y, word_t'($random(seed)), attr);
            end
        end
    endtask

    // expected words 0..2 per slot and the number of sprite tiles
    function automatic int build_expected(input vpos_t vline);
        obj_entry_t cur;
        obj_entry_t prev;
        logic       have_prev;
        logic       dup;
        vpos_t      row;
        logic [9:0] span;
        nib_t       vsub;
        int         slot;
        int         k;
        int         n;
        slot      = 0;
        have_prev = 1'b0;
        prev      = '0;
        for (int i = 0; i < exp_words; i++)
            exp_tab[i] = fill_word;
        k = entry_cnt - 1;
        while (k >= 0 && slot < line_slots) begin
            cur       = {ftab[4*k], ftab[4*k+1], ftab[4*k+2], ftab[4*k+3]};
            dup       = have_prev && (cur == prev);
            prev      = cur;
            have_prev = 1'b1;
            row  = vline - cur.y[vpos_w-1:0];
            span = 10'(cur.attr[15:12]) * 10'd16 + 10'd16;
            vsub = cur.attr[6] ? ~row[3:0] : row[3:0];
            if (10'(row) < span && !dup) begin
                n = 0;
                while (n <= int'(cur.attr[11:8]) && slot < line_slots) begin
                    exp_tab[3*slot]   = {4'd0, vsub, cur.attr[7:0]};
                    exp_tab[3*slot+1] = {cur.code[15:8], cur.code[7:4] + row[7:4],
                                         cur.code[3:0] + 4'(n)};
                    exp_tab[3*slot+2] = cur.x + word_t'(16 * n);
                    slot++;
                    n++;
                end
            end
            k--;
        end
        return slot;
    endfunction

    task automatic run_scan(input string name, input vpos_t vline);
        int tiles;
        int errs_before;
        errs_before = err_cnt;
        cur_test    = name;
        tiles       = build_expected(vline);
        @(posedge clk);
        #2;
        vrender = vline;
        start   = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
        check_value("done after start", 16'd0, word_t'(done));
        while (!done) begin
            @(posedge clk);
            #2;
        end
        vrender = vpos_t'(vline + 9'd1);  // swap banks so the new line is readable
        for (int s = 0; s < line_slots; s++) begin
            for (int w = 0; w < 3; w++) begin
                line_addr = {7'(s), 2'(w)};
                @(posedge clk);
                #2;
                check_value($sformatf("slot %0d word %0d", s, w), exp_tab[3*s+w], line_data);
            end
        end
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("test %s: %0d tiles, ok", name, tiles);
        end else begin
            fail_cnt++;
            $display("test %s: %0d tiles, %0d mismatches", name, tiles, err_cnt - errs_before);
        end
    endtask

    initial begin
        vpos_t rand_line;
        seed      = 32'hd64a2720;
        err_cnt   = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        clk       = 1'b0;
        rst       = 1'b1;
        vrender   = '0;
        start     = 1'b0;
        line_addr = '0;
        clear_table(9'd0);
        repeat (4) @(posedge clk);
        #2;
        check_reset();
        rst = 1'b0;

        clear_table(9'd40);
        run_scan("empty_line", 9'd40);

        clear_table(9'd81);
        put_entry(100, 16'd200, 16'd76, 16'h1230, 16'h0327);  // 4 tiles across on row 5
        run_scan("wide_sprite", 9'd81);

        clear_table(9'd300);
        put_entry(180, 16'd64, 16'd261, 16'h0a40, 16'h2003);  // row 39 in the third tile row
        put_entry(90, 16'd96, 16'd261, 16'h0b50, 16'h214c);   // same row with vflip
        run_scan("tall_sprite", 9'd300);

        clear_table(9'd123);
        put_entry(200, 16'd10, 16'd120, 16'h2200, 16'h0101);
        put_entry(199, 16'd10, 16'd120, 16'h2200, 16'h0101);
        put_entry(150, 16'd40, 16'd115, 16'h3300, 16'h0002);
        put_entry(120, 16'd40, 16'd115, 16'h3300, 16'h0002);
        run_scan("repeat_filter", 9'd123);

        clear_table(9'd222);
        for (int i = 0; i < 10; i++)  // 150 tiles wanted
            put_entry(250 - 3*i, word_t'(32*i), 16'd220, word_t'(16'h4000 + 16'h0100*i),
                      word_t'(16'h0e00 + i));
        run_scan("overflow", 9'd222);

        for (int t = 0; t < 3; t++) begin
            rand_line    = vpos_t'($random(seed));
            rand_line[0] = (t % 2 == 0);
            random_table(rand_line);
            run_scan($sformatf("random_%0d", t), rand_line);
        end

        $display("tests run %0d, passed %0d, failed %0d", pass_cnt + fail_cnt, pass_cnt, fail_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
